// File: source/segment_chase_pkg.sv
package segment_chase_pkg;

    // Segment count of one digit, A through G
    localparam int NUM_SEGS = 7;

    typedef enum logic [1:0] {
        PH_INIT  = 2'd0,
        PH_MOVE  = 2'd1,
        PH_TRAIL = 2'd2
    } phase_e;

    // Index into the record and the segment output
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_e;

    typedef enum logic [1:0] {
        HD_RIGHT = 2'd0,
        HD_LEFT  = 2'd1,
        HD_UP    = 2'd2,
        HD_DOWN  = 2'd3
    } heading_e;

    // Raw button levels or one-cycle press pulses
    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } buttons_t;

    // Dot state from the walker
    typedef struct packed {
        seg_e     seg;
        heading_e heading;
        logic     moved;
    } walk_t;

    // Game state from the controller
    typedef struct packed {
        phase_e              phase;
        logic [NUM_SEGS-1:0] record;
        logic                tick;
    } ctrl_t;

endpackage

// File: source/button_conditioner.sv
module button_conditioner #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  segment_chase_pkg::buttons_t raw,
    output segment_chase_pkg::buttons_t press
);

    localparam int NUM_BUTTONS = $bits(segment_chase_pkg::buttons_t);

    logic [NUM_BUTTONS-1:0]  raw_bits;
    logic [DEBOUNCE_LEN-1:0] samples [NUM_BUTTONS];
    logic [NUM_BUTTONS-1:0]  level;
    logic [NUM_BUTTONS-1:0]  level_q;

    assign raw_bits = raw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                samples[i] <= '0;
            end
            level_q <= '0;
        end else begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                samples[i] <= (samples[i] << 1) | DEBOUNCE_LEN'(raw_bits[i]);
            end
            level_q <= level;
        end
    end

    // Stable high once every sample in the window is high
    always_comb begin
        for (int i = 0; i < NUM_BUTTONS; i++) begin
            level[i] = &samples[i];
        end
    end

    // Rising edge of the debounced level, one cycle wide
    assign press = segment_chase_pkg::buttons_t'(level & ~level_q);

endmodule

// File: source/segment_walker.sv
module segment_walker (
    input  logic                        clk,
    input  logic                        rst,
    input  segment_chase_pkg::buttons_t press,
    input  segment_chase_pkg::ctrl_t    ctrl,
    output segment_chase_pkg::walk_t    walk
);

    segment_chase_pkg::seg_e     seg_q;
    segment_chase_pkg::heading_e heading_q;
    logic                        moved_q;
    segment_chase_pkg::walk_t    nxt;
    logic                        hd_right;
    logic                        hd_left;
    logic                        hd_up;
    logic                        hd_down;

    function automatic segment_chase_pkg::walk_t step(segment_chase_pkg::seg_e s,
                                                      segment_chase_pkg::heading_e h);
        return '{seg: s, heading: h, moved: 1'b1};
    endfunction

    assign hd_right = heading_q == segment_chase_pkg::HD_RIGHT;
    assign hd_left  = heading_q == segment_chase_pkg::HD_LEFT;
    assign hd_up    = heading_q == segment_chase_pkg::HD_UP;
    assign hd_down  = heading_q == segment_chase_pkg::HD_DOWN;

    // Walk table, left beats right beats up within one heading
    always_comb begin
        nxt = '{seg: seg_q, heading: heading_q, moved: 1'b0};
        case (seg_q)
            segment_chase_pkg::SEG_A: begin
                if (hd_right && press.right)
                    nxt = step(segment_chase_pkg::SEG_B, segment_chase_pkg::HD_DOWN);
                else if (hd_left && press.left)
                    nxt = step(segment_chase_pkg::SEG_F, segment_chase_pkg::HD_DOWN);
            end
            segment_chase_pkg::SEG_B: begin
                if (hd_up && press.left)
                    nxt = step(segment_chase_pkg::SEG_A, segment_chase_pkg::HD_LEFT);
                else if (hd_down && press.right)
                    nxt = step(segment_chase_pkg::SEG_G, segment_chase_pkg::HD_LEFT);
                else if (hd_down && press.up)
                    nxt = step(segment_chase_pkg::SEG_C, segment_chase_pkg::HD_DOWN);
            end
            segment_chase_pkg::SEG_C: begin
                if (hd_up && press.left)
                    nxt = step(segment_chase_pkg::SEG_G, segment_chase_pkg::HD_LEFT);
                else if (hd_up && press.up)
                    nxt = step(segment_chase_pkg::SEG_B, segment_chase_pkg::HD_UP);
                else if (hd_down && press.right)
                    nxt = step(segment_chase_pkg::SEG_D, segment_chase_pkg::HD_DOWN);
            end
            segment_chase_pkg::SEG_D: begin
                if (hd_right && press.left)
                    nxt = step(segment_chase_pkg::SEG_C, segment_chase_pkg::HD_UP);
                else if (hd_left && press.right)
                    nxt = step(segment_chase_pkg::SEG_E, segment_chase_pkg::HD_UP);
            end
            segment_chase_pkg::SEG_E: begin
                if (hd_up && press.right)
                    nxt = step(segment_chase_pkg::SEG_G, segment_chase_pkg::HD_RIGHT);
                else if (hd_up && press.up)
                    nxt = step(segment_chase_pkg::SEG_F, segment_chase_pkg::HD_UP);
                else if (hd_down && press.left)
                    nxt = step(segment_chase_pkg::SEG_D, segment_chase_pkg::HD_RIGHT);
            end
            segment_chase_pkg::SEG_F: begin
                if (hd_up && press.right)
                    nxt = step(segment_chase_pkg::SEG_A, segment_chase_pkg::HD_RIGHT);
                else if (hd_down && press.left)
                    nxt = step(segment_chase_pkg::SEG_G, segment_chase_pkg::HD_RIGHT);
            end
            segment_chase_pkg::SEG_G: begin
                if (hd_right && press.left)
                    nxt = step(segment_chase_pkg::SEG_B, segment_chase_pkg::HD_UP);
                else if (hd_right && press.right)
                    nxt = step(segment_chase_pkg::SEG_C, segment_chase_pkg::HD_DOWN);
                else if (hd_left && press.left)
                    nxt = step(segment_chase_pkg::SEG_E, segment_chase_pkg::HD_DOWN);
                else if (hd_left && press.right)
                    nxt = step(segment_chase_pkg::SEG_F, segment_chase_pkg::HD_UP);
            end
            default: begin
                nxt = step(segment_chase_pkg::SEG_G, segment_chase_pkg::HD_LEFT);
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_q     <= segment_chase_pkg::SEG_G;
            heading_q <= segment_chase_pkg::HD_LEFT;
            moved_q   <= 1'b0;
        end else if (ctrl.phase == segment_chase_pkg::PH_INIT) begin
            // Parked at the start position
            seg_q     <= segment_chase_pkg::SEG_G;
            heading_q <= segment_chase_pkg::HD_LEFT;
            moved_q   <= 1'b0;
        end else begin
            seg_q     <= nxt.seg;
            heading_q <= nxt.heading;
            moved_q   <= nxt.moved;
        end
    end

    assign walk = '{seg: seg_q, heading: heading_q, moved: moved_q};

endmodule

// File: source/game_controller.sv
module game_controller #(
    parameter int TICK_DIV         = 2 ** 20,
    parameter int INIT_TICKS       = 3,
    parameter int TRAIL_HOLD_TICKS = 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  segment_chase_pkg::buttons_t press,
    input  segment_chase_pkg::walk_t    walk,
    output segment_chase_pkg::ctrl_t    ctrl
);

    localparam int DIV_W = $clog2(TICK_DIV) > 0 ? $clog2(TICK_DIV) : 1;
    localparam int MAX_TICKS = INIT_TICKS > TRAIL_HOLD_TICKS ? INIT_TICKS : TRAIL_HOLD_TICKS;
    localparam int CNT_W = $clog2(MAX_TICKS) + 1;

    logic [DIV_W-1:0]                       div_cnt;
    logic                                   tick_q;
    logic [CNT_W-1:0]                       tick_cnt;
    segment_chase_pkg::phase_e              phase_q;
    logic [segment_chase_pkg::NUM_SEGS-1:0] record_q;
    logic [segment_chase_pkg::NUM_SEGS-1:0] mark;
    logic                                   full;

    // Tick divider, free running out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick_q  <= 1'b0;
        end else begin
            tick_q <= div_cnt == DIV_W'(TICK_DIV - 1);
            if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        mark = '0;
        mark[walk.seg] = 1'b1;
    end

    assign full = &record_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q  <= segment_chase_pkg::PH_INIT;
            tick_cnt <= '0;
            record_q <= '0;
        end else begin
            case (phase_q)
                segment_chase_pkg::PH_INIT: begin
                    if (tick_q && tick_cnt == CNT_W'(INIT_TICKS - 1)) begin
                        phase_q  <= segment_chase_pkg::PH_MOVE;
                        tick_cnt <= '0;
                    end else if (tick_q) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                segment_chase_pkg::PH_MOVE: begin
                    if (press.down) begin
                        phase_q  <= segment_chase_pkg::PH_TRAIL;
                        record_q <= mark;
                    end
                end
                segment_chase_pkg::PH_TRAIL: begin
                    if (walk.moved) begin
                        record_q <= record_q | mark;
                    end
                    // Hold time runs only once every segment is visited
                    if (full && tick_q && tick_cnt == CNT_W'(TRAIL_HOLD_TICKS - 1)) begin
                        phase_q  <= segment_chase_pkg::PH_INIT;
                        tick_cnt <= '0;
                        record_q <= '0;
                    end else if (full && tick_q) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    phase_q  <= segment_chase_pkg::PH_INIT;
                    tick_cnt <= '0;
                    record_q <= '0;
                end
            endcase
        end
    end

    assign ctrl = '{phase: phase_q, record: record_q, tick: tick_q};

endmodule

// File: source/segment_renderer.sv
module segment_renderer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  segment_chase_pkg::walk_t               walk,
    input  segment_chase_pkg::ctrl_t               ctrl,
    output logic [segment_chase_pkg::NUM_SEGS-1:0] seg_n
);

    logic [segment_chase_pkg::NUM_SEGS-1:0] lit;
    logic                                   blink;

    // Lit segments, active high
    always_comb begin
        lit = '0;
        case (ctrl.phase)
            segment_chase_pkg::PH_MOVE: begin
                lit[walk.seg] = 1'b1;
            end
            segment_chase_pkg::PH_TRAIL: begin
                lit = ctrl.record;
                lit[walk.seg] = ctrl.record[walk.seg] ^ blink;
            end
            default: begin
                lit[segment_chase_pkg::SEG_G] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink <= 1'b0;
            seg_n <= '1;
            seg_n[segment_chase_pkg::SEG_G] <= 1'b0;
        end else begin
            if (ctrl.tick) begin
                blink <= ~blink;
            end
            seg_n <= ~lit;
        end
    end

endmodule

// File: source/segment_chase_top.sv
module segment_chase_top #(
    parameter int DEBOUNCE_LEN     = 4,
    parameter int TICK_DIV         = 2 ** 20,
    parameter int INIT_TICKS       = 3,
    parameter int TRAIL_HOLD_TICKS = 1
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  segment_chase_pkg::buttons_t            buttons,
    output logic [segment_chase_pkg::NUM_SEGS-1:0] seg_n,
    output segment_chase_pkg::phase_e              phase,
    output segment_chase_pkg::heading_e            heading
);

    segment_chase_pkg::buttons_t press;
    segment_chase_pkg::walk_t    walk;
    segment_chase_pkg::ctrl_t    ctrl;

    button_conditioner #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) u_button_conditioner (
        .clk  (clk),
        .rst  (rst),
        .raw  (buttons),
        .press(press)
    );

    segment_walker u_segment_walker (
        .clk  (clk),
        .rst  (rst),
        .press(press),
        .ctrl (ctrl),
        .walk (walk)
    );

    game_controller #(
        .TICK_DIV        (TICK_DIV),
        .INIT_TICKS      (INIT_TICKS),
        .TRAIL_HOLD_TICKS(TRAIL_HOLD_TICKS)
    ) u_game_controller (
        .clk  (clk),
        .rst  (rst),
        .press(press),
        .walk (walk),
        .ctrl (ctrl)
    );

    segment_renderer u_segment_renderer (
        .clk  (clk),
        .rst  (rst),
        .walk (walk),
        .ctrl (ctrl),
        .seg_n(seg_n)
    );

    assign phase   = ctrl.phase;
    assign heading = walk.heading;

endmodule

// File: tests/segment_chase_assert.sv
module segment_chase_assert (
    input logic                                   clk,
    input logic                                   rst,
    input segment_chase_pkg::phase_e              phase,
    input logic [segment_chase_pkg::NUM_SEGS-1:0] record
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;

    init_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> phase == segment_chase_pkg::PH_INIT
    ) else begin
        error_count++;
        $error("phase is not INIT in the cycle after reset");
    end

    // Only the three defined phases
    legal_phase: assert property (
        @(posedge clk) disable iff (rst)
        phase inside {segment_chase_pkg::PH_INIT, segment_chase_pkg::PH_MOVE,
                      segment_chase_pkg::PH_TRAIL}
    ) else begin
        error_count++;
        $error("phase holds an undefined value");
    end

    record_stable_in_move: assert property (
        @(posedge clk) disable iff (rst)
        phase == segment_chase_pkg::PH_MOVE |-> $stable(record)
    ) else begin
        error_count++;
        $error("record changed during MOVE");
    end

endmodule

bind game_controller segment_chase_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .phase (phase_q),
    .record(record_q)
);

// File: tests/segment_chase_tb.sv
module segment_chase_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEBOUNCE_LEN     = 4;
    localparam int TICK_DIV         = 8;
    localparam int INIT_TICKS       = 3;
    localparam int TRAIL_HOLD_TICKS = 1;
    localparam int DRIVE_DELAY      = 2;
    localparam int PRESS            = DEBOUNCE_LEN + 2;
    localparam int LONG_HOLD        = 5 * PRESS;
    localparam int NUM_STEPS        = 13;
    localparam logic [6:0] ALL      = '1;

    localparam segment_chase_pkg::phase_e   INIT    = segment_chase_pkg::PH_INIT;
    localparam segment_chase_pkg::phase_e   MOVE    = segment_chase_pkg::PH_MOVE;
    localparam segment_chase_pkg::phase_e   TRAIL   = segment_chase_pkg::PH_TRAIL;
    localparam segment_chase_pkg::heading_e H_RIGHT = segment_chase_pkg::HD_RIGHT;
    localparam segment_chase_pkg::heading_e H_LEFT  = segment_chase_pkg::HD_LEFT;
    localparam segment_chase_pkg::heading_e H_UP    = segment_chase_pkg::HD_UP;
    localparam segment_chase_pkg::heading_e H_DOWN  = segment_chase_pkg::HD_DOWN;
    localparam segment_chase_pkg::buttons_t B_RIGHT = '{right: 1'b1, default: 1'b0};
    localparam segment_chase_pkg::buttons_t B_LEFT  = '{left: 1'b1, default: 1'b0};
    localparam segment_chase_pkg::buttons_t B_UP    = '{up: 1'b1, default: 1'b0};
    localparam segment_chase_pkg::buttons_t B_DOWN  = '{down: 1'b1, default: 1'b0};

    logic                                   clk;
    logic                                   rst;
    segment_chase_pkg::buttons_t            buttons;
    logic [segment_chase_pkg::NUM_SEGS-1:0] seg_n;
    segment_chase_pkg::phase_e              phase;
    segment_chase_pkg::heading_e            heading;

    // Stimulus table, seg_n is active low with bit 0 for A
    string                       step_name    [NUM_STEPS];
    segment_chase_pkg::buttons_t step_btn     [NUM_STEPS];
    logic [6:0]                  step_seg_n   [NUM_STEPS];
    logic [6:0]                  step_care    [NUM_STEPS];
    segment_chase_pkg::phase_e   step_phase   [NUM_STEPS];
    segment_chase_pkg::heading_e step_heading [NUM_STEPS];
    int                          step_hold    [NUM_STEPS];
    int                          num_steps = 0;

    segment_chase_top #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN),
        .TICK_DIV    (TICK_DIV)
    ) u_dut (
        .clk    (clk),
        .rst    (rst),
        .buttons(buttons),
        .seg_n  (seg_n),
        .phase  (phase),
        .heading(heading)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_STEPS * 40 + 400) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", NUM_STEPS * 40 + 400);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic add_step(string name, segment_chase_pkg::buttons_t b, logic [6:0] exp,
                            logic [6:0] care, segment_chase_pkg::phase_e ph,
                            segment_chase_pkg::heading_e hd, int hold);
        step_name[num_steps]    = name;
        step_btn[num_steps]     = b;
        step_seg_n[num_steps]   = exp;
        step_care[num_steps]    = care;
        step_phase[num_steps]   = ph;
        step_heading[num_steps] = hd;
        step_hold[num_steps]    = hold;
        num_steps++;
    endtask

    // Walker and renderer follow a phase change one cycle later
    task automatic wait_for_phase(string name, segment_chase_pkg::phase_e target, int limit);
        int n;
        n = 0;
        while (phase != target && n < limit) begin
            wait_cycles(1);
            n++;
        end
        check(name, target, phase);
        wait_cycles(1);
    endtask

    initial begin
        rst     = 1'b1;
        buttons = '0;
        add_step("no_entry_up", B_UP, 7'b0111111, ALL, MOVE, H_LEFT, PRESS);
        add_step("g_right_to_f", B_RIGHT, 7'b1011111, ALL, MOVE, H_UP, PRESS);
        // A second pulse here would carry on to B
        add_step("f_right_held", B_RIGHT, 7'b1111110, ALL, MOVE, H_RIGHT, LONG_HOLD);
        add_step("a_right_to_b", B_RIGHT, 7'b1111101, ALL, MOVE, H_DOWN, PRESS);
        add_step("b_left_no_entry", B_LEFT, 7'b1111101, ALL, MOVE, H_DOWN, PRESS);
        add_step("b_right_to_g", B_RIGHT, 7'b0111111, ALL, MOVE, H_LEFT, PRESS);
        // Blinking current segment is masked out in TRAIL
        add_step("down_to_trail", B_DOWN, 7'b1111111, 7'b0111111, TRAIL, H_LEFT, PRESS);
        add_step("trail_left_wins", B_LEFT | B_RIGHT, 7'b0111111, 7'b1101111, TRAIL, H_DOWN,
                 PRESS);
        add_step("trail_e_to_d", B_LEFT, 7'b0101111, 7'b1110111, TRAIL, H_RIGHT, PRESS);
        add_step("trail_d_to_c", B_LEFT, 7'b0100111, 7'b1111011, TRAIL, H_UP, PRESS);
        add_step("trail_c_to_b", B_UP, 7'b0100011, 7'b1111101, TRAIL, H_UP, PRESS);
        add_step("trail_b_to_a", B_LEFT, 7'b0100001, 7'b1111110, TRAIL, H_LEFT, PRESS);
        add_step("trail_a_to_f_done", B_LEFT, 7'b0111111, ALL, INIT, H_LEFT, PRESS);

        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check("reset_phase", INIT, phase);
        check("reset_heading", H_LEFT, heading);
        check("reset_seg_n", 7'b0111111, seg_n);
        wait_for_phase("init_to_move", MOVE, INIT_TICKS * TICK_DIV + 2);

        for (int i = 0; i < NUM_STEPS; i++) begin
            buttons = step_btn[i];
            wait_cycles(step_hold[i]);
            buttons = '0;
            wait_cycles(PRESS);
            if (step_phase[i] == INIT) begin
                wait_for_phase(step_name[i], INIT, (TRAIL_HOLD_TICKS + 1) * TICK_DIV + 2);
            end
            check({step_name[i], " phase"}, step_phase[i], phase);
            check({step_name[i], " seg_n"}, step_seg_n[i] & step_care[i],
                  seg_n & step_care[i]);
            check({step_name[i], " heading"}, step_heading[i], heading);
        end

        if (u_dut.u_game_controller.u_assert.error_count != 0) begin
            $display("Concurrent assertions failed %0d times",
                     u_dut.u_game_controller.u_assert.error_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: segment_chase_top.f
source/segment_chase_pkg.sv
source/button_conditioner.sv
source/segment_walker.sv
source/game_controller.sv
source/segment_renderer.sv
source/segment_chase_top.sv
tests/segment_chase_assert.sv
tests/segment_chase_tb.sv

// File: Bender.yml
package:
  name: segment_chase

sources:
  - source/segment_chase_pkg.sv
  - source/button_conditioner.sv
  - source/segment_walker.sv
  - source/game_controller.sv
  - source/segment_renderer.sv
  - source/segment_chase_top.sv
  - target: test
    files:
      - tests/segment_chase_assert.sv
      - tests/segment_chase_tb.sv
